/* addrPkg.sv */
`default_nettype none

package addrPkg;

  // cache geometry, 8 direct-mapped sets
  parameter int indexBits = 3;
  parameter int numSets = 1 << indexBits;

  // tag is whatever sits above index, word and byte fields
  parameter int tagBits = 32 - indexBits - 4;

  // pc as seen by the tag and data stores
  typedef struct packed {
    logic [tagBits-1:0]   tag;
    logic [indexBits-1:0] index;
    logic [1:0]           wordSel;
    logic [1:0]           byteSel;
  } cacheFields;

  // pc as seen by the backing memory, one block per 16 bytes
  typedef struct packed {
    logic [27:0] blockNum;
    logic [1:0]  wordSel;
    logic [1:0]  byteSel;
  } memFields;

  // one fetch address, two decodings
  typedef union packed {
    cacheFields cacheView;
    memFields   memView;
  } fetchAddr;

endpackage

`default_nettype wire

/* memPkg.sv */
`default_nettype none

package memPkg;

  // one instruction
  typedef logic [31:0] instrWord;

  // refill unit is a four-word block
  parameter int wordsPerBlock = 4;

  // entry 0 holds the lowest address of the block
  typedef instrWord [wordsPerBlock-1:0] memBlock;

  // backing memory depth in words
  parameter int memWords = 64;

  // hex image, one word per line
  parameter string memFile = "imem.dat";

endpackage

`default_nettype wire

/* tagStore.sv */
`default_nettype none

module tagStore
  (
    input  logic             clk,
    input  logic             rstN,
    input  addrPkg::fetchAddr pcReg,
    input  logic             fillEn,
    input  logic             flush,
    output logic             hit
  );

  import addrPkg::*;

  // one valid bit per set
  logic [numSets-1:0] valid;

  // tag array
  logic [tagBits-1:0] tagMem [numSets];

  // valid bits clear on reset and on flush
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      valid <= '0;
    end
    else if (flush)
    begin
      valid <= '0;
    end
    else if (fillEn)
    begin
      // refilled set becomes usable
      valid[pcReg.cacheView.index] <= 1'b1;
    end
  end

  // tag captured with the block
  always_ff @(posedge clk)
  begin
    if (fillEn)
    begin
      tagMem[pcReg.cacheView.index] <= pcReg.cacheView.tag;
    end
  end

  // selected set must be valid and carry the same tag
  assign hit = valid[pcReg.cacheView.index] &&
               (tagMem[pcReg.cacheView.index] == pcReg.cacheView.tag);

endmodule

`default_nettype wire

/* dataStore.sv */
`default_nettype none

module dataStore
  (
    input  logic              clk,
    input  addrPkg::fetchAddr pcReg,
    input  logic              fillEn,
    input  memPkg::memBlock   block,
    output memPkg::instrWord  instr
  );

  import addrPkg::*;
  import memPkg::*;

  // one whole block per set
  memBlock blockMem [numSets];

  // set index and word within the block
  logic [indexBits-1:0] setIdx;
  logic [1:0]           wordIdx;

  // byte bits are not looked at, fetches are word aligned
  assign setIdx  = pcReg.cacheView.index;
  assign wordIdx = pcReg.cacheView.wordSel;

  // block lands in address order
  always_ff @(posedge clk)
  begin
    if (fillEn)
    begin
      blockMem[setIdx] <= block;
    end
  end

  // word select from the indexed set
  // stale until a fill, the controller only reads it on a hit
  assign instr = blockMem[setIdx][wordIdx];

endmodule

`default_nettype wire

/* blockMemory.sv */
`default_nettype none

module blockMemory
  #(
    parameter int waitCycles = 2
  )
  (
    input  logic              clk,
    input  logic              rstN,
    input  logic              memRead,
    input  addrPkg::fetchAddr pcReg,
    output memPkg::memBlock   block,
    output logic              memValid
  );

  import memPkg::*;

  // counter must reach waitCycles
  localparam int countBits = $clog2(waitCycles + 1);
  // word and block address widths inside the array
  localparam int wordAddrBits = $clog2(memWords);
  localparam int wordOffBits = $clog2(wordsPerBlock);
  localparam int blockAddrBits = wordAddrBits - wordOffBits;

  typedef enum logic [1:0] {idle, requested, retrieved} memState;

  memState state;
  memState nextState;
  logic [countBits-1:0] count;
  logic [blockAddrBits-1:0] blockAddr;

  // word array
  instrWord mem [memWords];

  initial
  begin
    $readmemh(memFile, mem);
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state <= idle;
    end
    else
    begin
      state <= nextState;
    end
  end

  // stay in requested while the wait is not done
  always_comb
  begin
    case (state)
      idle:      nextState = memRead ? requested : idle;
      requested: nextState = (count < countBits'(waitCycles)) ? requested : retrieved;
      retrieved: nextState = idle;
      default:   nextState = idle;
    endcase
  end

  // wait counter, held at zero while idle
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      count <= '0;
    end
    else if (state == idle)
    begin
      count <= '0;
    end
    else if (state == requested)
    begin
      count <= count + 1'b1;
    end
  end

  // block valid for exactly the retrieved cycle
  assign memValid = (state == retrieved);

  // block number wraps modulo the memory depth
  assign blockAddr = pcReg.memView.blockNum[blockAddrBits-1:0];

  always_comb
  begin
    for (int w = 0; w < wordsPerBlock; w++)
    begin
      block[w] = mem[{blockAddr, wordOffBits'(w)}];
    end
  end

endmodule

`default_nettype wire

/* icacheCtrl.sv */
`default_nettype none

module icacheCtrl
  (
    input  logic              clk,
    input  logic              rstN,
    input  logic              fetchReq,
    input  addrPkg::fetchAddr pc,
    input  logic              hit,
    input  logic              memValid,
    output addrPkg::fetchAddr pcReg,
    output logic              memRead,
    output logic              fillEn,
    output logic              instrValid
  );

  typedef enum logic [1:0] {idle, compare, refill, respond} ctrlState;

  ctrlState state;
  ctrlState nextState;

  // latch the request address once, when leaving idle
  always_ff @(posedge clk)
  begin
    if ((state == idle) && fetchReq)
    begin
      pcReg <= pc;
    end
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state <= idle;
    end
    else
    begin
      state <= nextState;
    end
  end

  always_comb
  begin
    case (state)
      idle:
      begin
        nextState = fetchReq ? compare : idle;
      end
      compare:
      begin
        // a miss leaves for refill, the read goes out this cycle
        nextState = hit ? respond : refill;
      end
      refill:
      begin
        // after the fill, look up again so the word comes from the cache
        nextState = memValid ? compare : refill;
      end
      respond:
      begin
        nextState = idle;
      end
      default:
      begin
        nextState = idle;
      end
    endcase
  end

  // single read per miss, compare only lasts one cycle
  assign memRead = (state == compare) && !hit;

  // write the stores in the cycle the block arrives
  assign fillEn = (state == refill) && memValid;

  // response pulse, one cycle
  assign instrValid = (state == respond);

endmodule

`default_nettype wire

/* fetchTop.sv */
`default_nettype none

module fetchTop
  #(
    parameter int waitCycles = 2
  )
  (
    input  logic              clk,
    input  logic              rstN,
    input  logic              fetchReq,
    input  addrPkg::fetchAddr pc,
    input  logic              flush,
    output memPkg::instrWord  instr,
    output logic              instrValid
  );

  import addrPkg::*;
  import memPkg::*;

  // latched address shared by stores and memory
  fetchAddr pcReg;
  // refill handshake
  logic    memRead;
  logic    memValid;
  logic    fillEn;
  memBlock block;
  // lookup result
  logic    hit;

  icacheCtrl ctrl (
    .clk(clk), .rstN(rstN), .fetchReq(fetchReq), .pc(pc), .hit(hit),
    .memValid(memValid), .pcReg(pcReg), .memRead(memRead), .fillEn(fillEn),
    .instrValid(instrValid)
  );

  tagStore tags (
    .clk(clk), .rstN(rstN), .pcReg(pcReg), .fillEn(fillEn), .flush(flush),
    .hit(hit)
  );

  // word goes straight to the requester
  dataStore data (
    .clk(clk), .pcReg(pcReg), .fillEn(fillEn), .block(block), .instr(instr)
  );

  // slow backing memory
  blockMemory #(
    .waitCycles(waitCycles)
  ) mem (
    .clk(clk), .rstN(rstN), .memRead(memRead), .pcReg(pcReg), .block(block),
    .memValid(memValid)
  );

endmodule

`default_nettype wire

/* fetchTb.sv */
`default_nettype none

module fetchTb;

  timeunit 1ns;
  timeprecision 100ps;

  import addrPkg::*;
  import memPkg::*;

  localparam int waitCycles = 2;
  // request sampled in idle to instrValid
  localparam int hitLatency = 2;
  localparam int missLatency = 2 + (waitCycles + 2) + 1;
  localparam int randomFetches = 200;
  // 5 fill and hit, 4 byte offset, 4 eviction and 2 flush fetches
  localparam int plannedFetches = 15 + randomFetches;
  localparam int cycleLimit = plannedFetches * 20;

  logic     clk;
  logic     rstN;
  logic     fetchReq;
  fetchAddr pc;
  logic     flush;
  instrWord instr;
  logic     instrValid;

  // expectations in request order
  logic [31:0] expWordQ [$];
  int          expLatQ [$];
  logic [31:0] expPcQ [$];

  // reference hit/miss model over the 8 sets
  logic [7:0]  refValid;
  logic [24:0] refTag [8];

  logic [31:0] rngState;
  int          errorCount;
  int          checkCount;
  int          cycleCount;

  fetchTop #(
    .waitCycles(waitCycles)
  ) dut (
    .clk(clk), .rstN(rstN), .fetchReq(fetchReq), .pc(pc), .flush(flush),
    .instr(instr), .instrValid(instrValid)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #10 clk = ~clk;
    end
  end

  // content rule with the word index wrapping at the 64-word depth
  function automatic logic [31:0] expectedWord(input logic [31:0] addr);
    logic [31:0] wordIdx;
    wordIdx = (addr >> 2) % 64;
    return 32'hE1A00000 + wordIdx * 32'h00010101;
  endfunction

  // 32-bit xorshift
  function automatic logic [31:0] nextRandom(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // predict hit or miss and fill the model set on a miss
  task automatic predictLatency(input logic [31:0] addr, output int lat);
    logic [2:0]  setIdx;
    logic [24:0] tagVal;
    setIdx = addr[6:4];
    tagVal = addr[31:7];
    if (refValid[setIdx] && (refTag[setIdx] == tagVal))
    begin
      lat = hitLatency;
    end
    else
    begin
      lat = missLatency;
      refValid[setIdx] = 1'b1;
      refTag[setIdx] = tagVal;
    end
  endtask

  // one fetch entered and left 2 ns after a rising edge
  task automatic issueFetch(input logic [31:0] addr);
    int lat;
    predictLatency(addr, lat);
    expWordQ.push_back(expectedWord(addr));
    expLatQ.push_back(lat);
    expPcQ.push_back(addr);
    pc = addr;
    fetchReq = 1'b1;
    // hold pc and request until the response pulse
    @(negedge clk);
    while (!instrValid)
    begin
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    fetchReq = 1'b0;
  endtask

  // one-cycle flush while idle
  task automatic pulseFlush();
    flush = 1'b1;
    @(posedge clk);
    #2;
    flush = 1'b0;
    refValid = '0;
  endtask

  // response checker counting latency in negedges after the request is seen
  initial
  begin : responseCheck
    logic        busy;
    int          latency;
    logic [31:0] expWord;
    int          expLat;
    logic [31:0] expPc;
    busy = 1'b0;
    latency = 0;
    forever
    begin
      @(negedge clk);
      if (busy)
      begin
        latency++;
        if (instrValid)
        begin
          busy = 1'b0;
          expWord = expWordQ.pop_front();
          expLat = expLatQ.pop_front();
          expPc = expPcQ.pop_front();
          checkCount++;
          assert (instr === expWord)
          else
          begin
            errorCount++;
            $display("Mismatch instr: got %h, expected %h (pc %h)", instr, expWord, expPc);
          end
          assert (latency == expLat)
          else
          begin
            errorCount++;
            $display("fetch at pc %h took %0d cycles instead of %0d",
                     expPc, latency, expLat);
          end
        end
      end
      else
      begin
        // no response while no fetch is outstanding
        assert (!instrValid)
        else
        begin
          errorCount++;
          $display("instrValid pulsed with no fetch outstanding");
        end
        if (fetchReq)
        begin
          busy = 1'b1;
          latency = 0;
        end
      end
    end
  end

  // run limit
  initial
  begin
    cycleCount = 0;
    while (cycleCount < cycleLimit)
    begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout, run did not finish within %0d cycles", cycleLimit);
    $display("** FAIL **");
    $finish;
  end

  initial
  begin
    errorCount = 0;
    checkCount = 0;
    rstN = 1'b0;
    fetchReq = 1'b0;
    pc = '0;
    flush = 1'b0;
    refValid = '0;
    rngState = 32'ha875c6d4;
    repeat (2) @(posedge clk);
    #2;
    rstN = 1'b1;

    // quiet outputs after reset with no request
    repeat (4)
    begin
      @(negedge clk);
      checkCount++;
      assert (!instrValid)
      else
      begin
        errorCount++;
        $display("instrValid high after reset without a request");
      end
    end
    @(posedge clk);
    #2;

    // cold miss on block 4 then hits on all its words
    issueFetch(32'h0000_0040);
    issueFetch(32'h0000_0040);
    issueFetch(32'h0000_0044);
    issueFetch(32'h0000_0048);
    issueFetch(32'h0000_004C);

    // byte bits ignored
    issueFetch(32'h0000_0041);
    issueFetch(32'h0000_0042);
    issueFetch(32'h0000_0043);
    issueFetch(32'h0000_004E);

    // set 4 shared by tags 0 and 1
    issueFetch(32'h0000_00C0);
    issueFetch(32'h0000_0040);
    issueFetch(32'h0000_00C4);
    issueFetch(32'h0000_0048);

    // hit then flush then the same pc misses
    issueFetch(32'h0000_0048);
    pulseFlush();
    issueFetch(32'h0000_0048);

    // random word addresses 0 to 255 with random byte bits
    repeat (randomFetches)
    begin
      rngState = nextRandom(rngState);
      issueFetch(rngState & 32'h0000_03FF);
    end

    repeat (2) @(negedge clk);
    assert (expWordQ.size() == 0)
    else
    begin
      errorCount++;
      $display("%0d fetches never got a response", expWordQ.size());
    end
    $display("checks %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0)
    begin
      $display("** PASS **");
    end
    else
    begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* imem.dat */
// one 32-bit instruction word per line in hex, word index 0 first
E1A00000
E1A10101
E1A20202
E1A30303
E1A40404
E1A50505
E1A60606
E1A70707
E1A80808
E1A90909
E1AA0A0A
E1AB0B0B
E1AC0C0C
E1AD0D0D
E1AE0E0E
E1AF0F0F
E1B01010
E1B11111
E1B21212
E1B31313
E1B41414
E1B51515
E1B61616
E1B71717
E1B81818
E1B91919
E1BA1A1A
E1BB1B1B
E1BC1C1C
E1BD1D1D
E1BE1E1E
E1BF1F1F
E1C02020
E1C12121
E1C22222
E1C32323
E1C42424
E1C52525
E1C62626
E1C72727
E1C82828
E1C92929
E1CA2A2A
E1CB2B2B
E1CC2C2C
E1CD2D2D
E1CE2E2E
E1CF2F2F
E1D03030
E1D13131
E1D23232
E1D33333
E1D43434
E1D53535
E1D63636
E1D73737
E1D83838
E1D93939
E1DA3A3A
E1DB3B3B
E1DC3C3C
E1DD3D3D
E1DE3E3E
E1DF3F3F

/* compile.f */
addrPkg.sv
memPkg.sv
tagStore.sv
dataStore.sv
blockMemory.sv
icacheCtrl.sv
fetchTop.sv
fetchTb.sv
